/* clock_domain_probe.sv */
`default_nettype none

module clock_domain_probe (
    input  wire                                      wb_clk_i,
    input  wire                                      rst_n_i,
    input  wire                                      clk_mon_i,
    output logic [turf_pkg::CLKMON_COUNT_BITS-1:0]   count_o,
    output logic                                     running_o
);

    // monitored domain, free running, no reset since the clock may be absent
    logic [turf_pkg::PROBE_DIV_BITS-1:0] div = '0;
    logic                                toggle = 1'b0;

    // bus domain
    logic [2:0]                                toggle_sync;
    logic                                      toggle_prev;
    logic                                      toggle_edge;
    logic [turf_pkg::CLKMON_WINDOW_BITS-1:0]   window_cnt;
    logic                                      window_end;
    logic [turf_pkg::CLKMON_COUNT_BITS-1:0]    edge_cnt;
    logic [turf_pkg::CLKMON_COUNT_BITS-1:0]    edge_cnt_nxt;

    // toggle flips when the divider wraps
    always_ff @(posedge clk_mon_i) begin
        div <= div + 1'b1;
        if (&div) begin
            toggle <= ~toggle;
        end
    end

    // both edges of the synced toggle count
    assign toggle_edge  = toggle_sync[2] ^ toggle_prev;
    assign window_end   = (window_cnt == turf_pkg::CLKMON_WINDOW_BITS'(turf_pkg::CLKMON_WINDOW - 1));
    assign edge_cnt_nxt = edge_cnt + {{(turf_pkg::CLKMON_COUNT_BITS-1){1'b0}}, toggle_edge};

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            toggle_sync <= 3'b000;
            toggle_prev <= 1'b0;
            window_cnt  <= '0;
            edge_cnt    <= '0;
            count_o     <= '0;
            running_o   <= 1'b0;
        end else begin
            // three-stage synchronizer
            toggle_sync <= {toggle_sync[1:0], toggle};
            toggle_prev <= toggle_sync[2];
            // window timer wraps on its own
            window_cnt  <= window_cnt + 1'b1;
            if (window_end) begin
                // latch including this cycle's edge, restart from zero
                count_o   <= edge_cnt_nxt;
                running_o <= (edge_cnt_nxt != '0);
                edge_cnt  <= '0;
            end else begin
                edge_cnt  <= edge_cnt_nxt;
            end
        end
    end

endmodule

`default_nettype wire

/* device_dna_port.sv */
`default_nettype none

// behavioral model of the device id port
// read loads the id, shift moves it one place toward bit 0
module device_dna_port (
    input  wire  wb_clk_i,
    input  wire  rst_n_i,
    input  wire  read_i,
    input  wire  shift_i,
    output logic dout_o
);

    // id shift register, lsb is the output bit
    logic [turf_pkg::DNA_WIDTH-1:0] dna_sr;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            dna_sr <= '0;
        end else if (read_i) begin
            // load has priority over shift
            dna_sr <= turf_pkg::DNA_ID;
        end else if (shift_i) begin
            // zero fill from the top
            dna_sr <= {1'b0, dna_sr[turf_pkg::DNA_WIDTH-1:1]};
        end
    end

    assign dout_o = dna_sr[0];

endmodule

`default_nettype wire

/* id_statctrl_regs.sv */
`default_nettype none

module id_statctrl_regs (
    input  wire         wb_clk_i,
    input  wire         rst_n_i,
    input  wire         en_i,
    input  wire         sec_i,
    input  wire  [1:0]  adr_i,
    input  wire         we_i,
    input  wire  [31:0] dat_i,
    input  wire         sel0_i,
    input  wire         dna_bit_i,
    output logic        ack_o,
    output logic [31:0] dat_o,
    output logic        dna_read_o,
    output logic        dna_shift_o,
    output logic        bitcmd_sync_o
);

    // control register, only bit 0 implemented
    logic        statctrl;
    // section 0 request, first cycle only
    logic        req_first;
    // section 0 access in its ack cycle
    logic        req_ack;
    // device id register addressed
    logic        dna_hit;
    logic        statctrl_hit;
    // read data before the output register
    logic [31:0] rd_dat;

    assign dna_hit      = (adr_i == turf_pkg::REG_DNA[3:2]);
    assign statctrl_hit = (adr_i == turf_pkg::REG_STATCTRL[3:2]);
    assign req_first    = en_i & sec_i & ~ack_o;
    assign req_ack      = en_i & sec_i & ack_o;

    // read mux by dword index
    always_comb begin
        case (adr_i)
            turf_pkg::REG_IDENT[3:2]:       rd_dat = turf_pkg::IDENT;
            turf_pkg::REG_DATEVERSION[3:2]: rd_dat = turf_pkg::DATEVERSION;
            turf_pkg::REG_DNA[3:2]:         rd_dat = {31'd0, dna_bit_i};
            default:                        rd_dat = {31'd0, statctrl};
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_o         <= 1'b0;
            statctrl      <= 1'b0;
            dna_read_o    <= 1'b0;
            dna_shift_o   <= 1'b0;
            bitcmd_sync_o <= 1'b0;
        end else begin
            // catch-all ack, one cycle after any request, then low for a cycle
            ack_o <= en_i & ~ack_o;

            // id strobes are high during the ack cycle, so the model
            // acts at the end of it, like any other write
            dna_read_o  <= req_first & dna_hit & we_i & dat_i[31];
            // current bit goes out in this ack, next one is ready after it
            dna_shift_o <= req_first & dna_hit & ~we_i;

            // write lands at the end of the ack cycle
            if (req_ack && statctrl_hit && we_i && sel0_i) begin
                statctrl <= dat_i[0];
            end

            // command sync level, one stage behind the register
            bitcmd_sync_o <= statctrl;
        end
    end

    // read data, captured in the request cycle and valid with ack
    always_ff @(posedge wb_clk_i) begin
        dat_o <= rd_dat;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# compile the testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_turf_id_ctrl \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1

/* simple_clock_mon.sv */
`default_nettype none

// one probe per clock, register n at dword n of the section
// bit 31 running flag, low bits window count
module simple_clock_mon (
    input  wire                                 wb_clk_i,
    input  wire                                 rst_n_i,
    input  wire                                 en_i,
    input  wire  [1:0]                          adr_i,
    input  wire  [turf_pkg::NUM_CLK_MON-1:0]    clk_mon_i,
    output logic                                ack_o,
    output logic [31:0]                         dat_o,
    output logic [turf_pkg::NUM_CLK_MON-1:0]    clk_running_o
);

    // per-clock window counts
    logic [turf_pkg::CLKMON_COUNT_BITS-1:0] probe_count [turf_pkg::NUM_CLK_MON];
    // per-clock running flags
    logic [turf_pkg::NUM_CLK_MON-1:0]       probe_running;
    // read data before the output register
    logic [31:0]                            rd_dat;

    for (genvar i = 0; i < turf_pkg::NUM_CLK_MON; i++) begin : g_probe
        clock_domain_probe u_probe (
            .wb_clk_i  (wb_clk_i),
            .rst_n_i   (rst_n_i),
            .clk_mon_i (clk_mon_i[i]),
            .count_o   (probe_count[i]),
            .running_o (probe_running[i])
        );
    end

    assign clk_running_o = probe_running;

    // index past the last clock reads zero
    always_comb begin
        if (adr_i < turf_pkg::NUM_CLK_MON) begin
            rd_dat = {probe_running[adr_i],
                      {(31 - turf_pkg::CLKMON_COUNT_BITS){1'b0}},
                      probe_count[adr_i]};
        end else begin
            rd_dat = 32'h0000_0000;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            // one ack per request, one cycle after it
            ack_o <= en_i & ~ack_o;
        end
    end

    // data captured in the request cycle
    always_ff @(posedge wb_clk_i) begin
        dat_o <= rd_dat;
    end

endmodule

`default_nettype wire

/* tb_turf_id_ctrl.sv */
`default_nettype none

module tb_turf_id_ctrl;

    timeunit 1ns;
    timeprecision 100ps;

    // bus clock and monitored clock periods in ns
    localparam int BUS_PERIOD  = 40;
    localparam int MON0_PERIOD = 10;
    localparam int MON1_PERIOD = 25;
    // bus cycles allowed before ack
    localparam int ACK_TIMEOUT = 8;
    // clock monitor base address with register n at base + 4n
    localparam logic [14:0] CLKMON_BASE = {turf_pkg::CLOCKMON_SECTION, 11'h000};

    logic        wb_clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [14:0] wb_adr;
    logic [31:0] wb_wdat;
    logic [3:0]  wb_sel;
    logic        mon_clk0;
    logic        mon_clk1;
    logic        mon_clk2;
    // clock 0 is stopped late in the run
    logic        mon0_run;
    wire         wb_ack;
    wire  [31:0] wb_rdat;
    wire  [2:0]  clk_ok;
    wire         bitcmd_sync;

    int errors;
    int tests_run;
    int tests_failed;
    int test_start_errors;
    int seed;

    turf_id_ctrl DUT (
        .wb_clk_i      (wb_clk),
        .rst_n_i       (rst_n),
        .wb_cyc_i      (wb_cyc),
        .wb_stb_i      (wb_stb),
        .wb_we_i       (wb_we),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_wdat),
        .wb_sel_i      (wb_sel),
        .clk_mon_i     ({mon_clk2, mon_clk1, mon_clk0}),
        .wb_ack_o      (wb_ack),
        .wb_dat_o      (wb_rdat),
        .clk_ok_o      (clk_ok),
        .bitcmd_sync_o (bitcmd_sync)
    );

    initial begin
        wb_clk = 1'b0;
        forever #(BUS_PERIOD / 2) wb_clk = ~wb_clk;
    end

    // monitored clock 0 halts when mon0_run drops
    initial begin
        mon_clk0 = 1'b0;
        forever begin
            #(MON0_PERIOD / 2.0);
            if (mon0_run) begin
                mon_clk0 = ~mon_clk0;
            end
        end
    end

    initial begin
        mon_clk1 = 1'b0;
        forever #(MON1_PERIOD / 2.0) mon_clk1 = ~mon_clk1;
    end

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("[ERROR] %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_range(input string what, input int got, input int lo, input int hi);
        assert (got >= lo && got <= hi)
        else begin
            $display("[ERROR] %0t: %s is %0d, expected %0d to %0d", $time, what, got, lo, hi);
            errors++;
        end
    endtask

    // one wishbone access with the request held until ack and sampled mid-cycle
    task automatic wb_access(input logic we, input logic [14:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel, output logic [31:0] rdat);
        int   waited;
        logic acked;
        waited = 0;
        acked  = 1'b0;
        rdat   = '0;
        @(posedge wb_clk);
        wb_cyc  <= 1'b1;
        wb_stb  <= 1'b1;
        wb_we   <= we;
        wb_adr  <= adr;
        wb_wdat <= wdat;
        wb_sel  <= sel;
        while (!acked && waited < ACK_TIMEOUT) begin
            @(negedge wb_clk);
            if (wb_ack) begin
                acked = 1'b1;
                rdat  = wb_rdat;
            end else begin
                waited++;
            end
        end
        @(posedge wb_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (!acked) begin
            $display("timeout: the DUT never acknowledged the access at 0x%04h", adr);
            errors++;
        end else begin
            // ack is due one bus cycle after the request
            check_range("ack latency in cycles", waited, 1, 1);
        end
    endtask

    task automatic wb_write(input logic [14:0] adr, input logic [31:0] wdat,
                            input logic [3:0] sel);
        logic [31:0] unused_rdat;
        wb_access(1'b1, adr, wdat, sel, unused_rdat);
    endtask

    task automatic wb_read(input logic [14:0] adr, output logic [31:0] rdat);
        wb_access(1'b0, adr, 32'h0000_0000, 4'hF, rdat);
    endtask

    task automatic wait_bitcmd(input logic level, input int max_cycles);
        int n;
        n = 0;
        @(negedge wb_clk);
        while (bitcmd_sync !== level && n < max_cycles) begin
            @(negedge wb_clk);
            n++;
        end
        if (bitcmd_sync !== level) begin
            $display("timeout: bitcmd_sync_o did not reach %0b in %0d cycles", level, max_cycles);
            errors++;
        end
    endtask

    // waits until the masked running flags match want
    task automatic wait_clk_ok(input logic [2:0] mask, input logic [2:0] want,
                               input int max_cycles);
        int n;
        n = 0;
        @(negedge wb_clk);
        while ((clk_ok & mask) !== want && n < max_cycles) begin
            @(negedge wb_clk);
            n++;
        end
        if ((clk_ok & mask) !== want) begin
            $display("timeout: clock flags stayed at %03b, waiting for %03b under mask %03b",
                     clk_ok, want, mask);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail with %0d errors", tests_run, name,
                     errors - test_start_errors);
        end
    endtask

    task automatic test_ident_unused();
        logic [31:0] rdat;
        logic [31:0] r;
        logic [3:0]  sec;
        test_start_errors = errors;
        wb_read(turf_pkg::REG_IDENT, rdat);
        check_equal("ident", rdat, "TURF");
        wb_read(turf_pkg::REG_DATEVERSION, rdat);
        check_equal("date/version", rdat, turf_pkg::DATEVERSION);
        assert (rdat != 32'h0)
        else begin
            $display("[ERROR] %0t: date/version word is zero", $time);
            errors++;
        end
        // sections 2 to 15 ack and read zero and writes there touch nothing
        for (int i = 0; i < 12; i++) begin
            r   = $random(seed);
            sec = 4'(2 + (r[7:0] % 14));
            wb_read({sec, r[18:10], 2'b00}, rdat);
            check_equal("unused section read", rdat, 32'h0);
            wb_write({sec, 11'h00C}, 32'h0000_0001, 4'hF);
        end
        end_test("ident and unused sections");
    endtask

    task automatic test_statctrl();
        logic [31:0] rdat;
        test_start_errors = errors;
        @(negedge wb_clk);
        check_equal("bitcmd_sync_o after reset", {31'd0, bitcmd_sync}, 32'd0);
        wb_read(turf_pkg::REG_STATCTRL, rdat);
        check_equal("statctrl after reset", rdat, 32'd0);
        wb_write(turf_pkg::REG_STATCTRL, 32'h0000_0001, 4'b0001);
        wait_bitcmd(1'b1, 4);
        wb_read(turf_pkg::REG_STATCTRL, rdat);
        check_equal("statctrl after set", rdat, 32'd1);
        // bit 0 keeps its value when sel bit 0 is clear
        wb_write(turf_pkg::REG_STATCTRL, 32'h0000_0000, 4'b1110);
        wb_read(turf_pkg::REG_STATCTRL, rdat);
        check_equal("statctrl after masked write", rdat, 32'd1);
        @(negedge wb_clk);
        check_equal("bitcmd_sync_o after masked write", {31'd0, bitcmd_sync}, 32'd1);
        wb_write(turf_pkg::REG_STATCTRL, 32'h0000_0000, 4'b0001);
        wb_read(turf_pkg::REG_STATCTRL, rdat);
        check_equal("statctrl after clear", rdat, 32'd0);
        wait_bitcmd(1'b0, 4);
        end_test("statctrl and command sync");
    endtask

    task automatic test_dna();
        logic [31:0]                    rdat;
        logic [turf_pkg::DNA_WIDTH-1:0] dna_bits;
        test_start_errors = errors;
        dna_bits = '0;
        wb_write(turf_pkg::REG_DNA, 32'h8000_0000, 4'hF);
        // one bit per read with the lsb first
        for (int i = 0; i < turf_pkg::DNA_WIDTH; i++) begin
            wb_read(turf_pkg::REG_DNA, rdat);
            check_equal("device id upper bits", {1'b0, rdat[31:1]}, 32'd0);
            dna_bits[i] = rdat[0];
        end
        assert (dna_bits === turf_pkg::DNA_ID)
        else begin
            $display("[ERROR] %0t: device id is 0x%024h, expected 0x%024h", $time,
                     dna_bits, turf_pkg::DNA_ID);
            errors++;
        end
        end_test("device id readout");
    endtask

    task automatic test_clock_running();
        logic [31:0] rdat;
        int          period;
        int          exp_cnt;
        test_start_errors = errors;
        wait_clk_ok(3'b011, 3'b011, 3 * turf_pkg::CLKMON_WINDOW + 32);
        for (int i = 0; i < 2; i++) begin
            period  = (i == 0) ? MON0_PERIOD : MON1_PERIOD;
            // both toggle edges count and the toggle flips every 2**div monitored cycles
            exp_cnt = (turf_pkg::CLKMON_WINDOW * BUS_PERIOD)
                      / ((1 << turf_pkg::PROBE_DIV_BITS) * period);
            wb_read(CLKMON_BASE + 15'(4 * i), rdat);
            check_equal("running flag", {31'd0, rdat[31]}, 32'd1);
            check_equal("count upper bits", {17'd0, rdat[30:16]}, 32'd0);
            check_range("window count", int'(rdat[15:0]), exp_cnt - 2, exp_cnt + 2);
            @(negedge wb_clk);
            check_equal("clk_ok_o of running clock", {31'd0, clk_ok[i]}, 32'd1);
        end
        end_test("running clocks");
    endtask

    task automatic test_clock_stop();
        logic [31:0] rdat;
        test_start_errors = errors;
        wb_read(CLKMON_BASE + 15'h008, rdat);
        check_equal("stopped clock register", rdat, 32'd0);
        @(negedge wb_clk);
        check_equal("stopped clock clk_ok_o", {31'd0, clk_ok[2]}, 32'd0);
        // index 3 is past the last clock
        wb_read(CLKMON_BASE + 15'h00C, rdat);
        check_equal("register past last clock", rdat, 32'd0);
        mon0_run = 1'b0;
        wait_clk_ok(3'b001, 3'b000, 2 * turf_pkg::CLKMON_WINDOW + 16);
        wb_read(CLKMON_BASE, rdat);
        check_equal("clock 0 register after stop", rdat, 32'd0);
        @(negedge wb_clk);
        check_equal("clock 1 clk_ok_o after clock 0 stop", {31'd0, clk_ok[1]}, 32'd1);
        end_test("stopped clocks");
    endtask

    initial begin
        rst_n        = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_wdat      = '0;
        wb_sel       = '0;
        mon_clk2     = 1'b0;
        mon0_run     = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed         = 32'h53427a00;
        repeat (2) @(posedge wb_clk);
        rst_n <= 1'b1;

        test_ident_unused();
        test_statctrl();
        test_dna();
        test_clock_running();
        test_clock_stop();

        $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* turf_id_ctrl.sv */
`default_nettype none

// address map, byte addresses
// 0x0000 - 0x07ff  id, version, device id, control
// 0x0800 - 0x0fff  clock monitor
// 0x1000 - 0x7fff  unused, acked and read as zero
module turf_id_ctrl (
    input  wire                                   wb_clk_i,
    input  wire                                   rst_n_i,
    input  wire                                   wb_cyc_i,
    input  wire                                   wb_stb_i,
    input  wire                                   wb_we_i,
    input  wire [turf_pkg::NUM_ADDRESS_BITS-1:0]  wb_adr_i,
    input  wire [31:0]                            wb_dat_i,
    input  wire [3:0]                             wb_sel_i,
    input  wire [turf_pkg::NUM_CLK_MON-1:0]       clk_mon_i,
    output logic                                  wb_ack_o,
    output logic [31:0]                           wb_dat_o,
    output logic [turf_pkg::NUM_CLK_MON-1:0]      clk_ok_o,
    output logic                                  bitcmd_sync_o
);

    // section field, top bits of the byte address
    logic [turf_pkg::NUM_SECTION_BITS-1:0] section;
    // live request, any section
    logic                                  bus_req;
    // section 0 addressed
    logic                                  id_statctrl_sec;
    // section 1 request
    logic                                  clockmon_en;
    // dword index inside a section
    logic [1:0]                            reg_adr;

    // section 0 block outputs
    logic        id_statctrl_ack;
    logic [31:0] id_statctrl_dat;
    logic        dna_read;
    logic        dna_shift;
    logic        dna_bit;

    // section 1 block outputs
    logic        clockmon_ack;
    logic [31:0] clockmon_dat;

    // catch-all ack, never seen outside a cycle
    logic        catchall_ack;

    assign section = wb_adr_i[turf_pkg::NUM_ADDRESS_BITS-1 -: turf_pkg::NUM_SECTION_BITS];
    assign bus_req = wb_cyc_i & wb_stb_i;
    assign reg_adr = wb_adr_i[3:2];

    assign id_statctrl_sec = (section == turf_pkg::ID_STATCTRL_SECTION);
    assign clockmon_en     = bus_req & (section == turf_pkg::CLOCKMON_SECTION);

    // register block acks every request, whatever the section
    id_statctrl_regs u_regs (
        .wb_clk_i      (wb_clk_i),
        .rst_n_i       (rst_n_i),
        .en_i          (bus_req),
        .sec_i         (id_statctrl_sec),
        .adr_i         (reg_adr),
        .we_i          (wb_we_i),
        .dat_i         (wb_dat_i),
        .sel0_i        (wb_sel_i[0]),
        .dna_bit_i     (dna_bit),
        .ack_o         (id_statctrl_ack),
        .dat_o         (id_statctrl_dat),
        .dna_read_o    (dna_read),
        .dna_shift_o   (dna_shift),
        .bitcmd_sync_o (bitcmd_sync_o)
    );

    // stand-in for the vendor device id port
    device_dna_port u_dna (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .read_i   (dna_read),
        .shift_i  (dna_shift),
        .dout_o   (dna_bit)
    );

    simple_clock_mon u_clkmon (
        .wb_clk_i      (wb_clk_i),
        .rst_n_i       (rst_n_i),
        .en_i          (clockmon_en),
        .adr_i         (reg_adr),
        .clk_mon_i     (clk_mon_i),
        .ack_o         (clockmon_ack),
        .dat_o         (clockmon_dat),
        .clk_running_o (clk_ok_o)
    );

    assign catchall_ack = id_statctrl_ack & wb_cyc_i;

    // ack and data select by section
    always_comb begin
        case (section)
            turf_pkg::ID_STATCTRL_SECTION: begin
                wb_ack_o = catchall_ack;
                wb_dat_o = id_statctrl_dat;
            end
            turf_pkg::CLOCKMON_SECTION: begin
                wb_ack_o = clockmon_ack;
                wb_dat_o = clockmon_dat;
            end
            default: begin
                // unused space, ack from the catch-all and zero data
                wb_ack_o = catchall_ack;
                wb_dat_o = 32'h0000_0000;
            end
        endcase
    end

endmodule

`default_nettype wire

/* turf_pkg.sv */
`default_nettype none

package turf_pkg;

    // wishbone byte address width
    localparam int NUM_ADDRESS_BITS = 15;
    // top address bits select one of sixteen sections
    localparam int NUM_SECTION_BITS = 4;

    // section codes
    localparam logic [NUM_SECTION_BITS-1:0] ID_STATCTRL_SECTION = 4'd0;
    localparam logic [NUM_SECTION_BITS-1:0] CLOCKMON_SECTION    = 4'd1;

    // byte offsets of the section 0 registers
    localparam logic [NUM_ADDRESS_BITS-1:0] REG_IDENT       = 15'h0000;
    localparam logic [NUM_ADDRESS_BITS-1:0] REG_DATEVERSION = 15'h0004;
    localparam logic [NUM_ADDRESS_BITS-1:0] REG_DNA         = 15'h0008;
    localparam logic [NUM_ADDRESS_BITS-1:0] REG_STATCTRL    = 15'h000C;

    // ascii "TURF", first character in the top byte
    localparam logic [31:0] IDENT = "TURF";
    // build/version word, fixed for this build
    localparam logic [31:0] DATEVERSION = 32'hA5C3_0102;

    // device unique id
    localparam int DNA_WIDTH = 96;
    // value returned by the behavioral id model, shifted out lsb first
    localparam logic [DNA_WIDTH-1:0] DNA_ID = 96'h4A6F_0C13_8E52_D7B1_2F90_6C35;

    // number of monitored external clocks
    localparam int NUM_CLK_MON = 3;
    // measurement window in bus clock cycles
    localparam int CLKMON_WINDOW = 1024;
    // width of the window cycle counter
    localparam int CLKMON_WINDOW_BITS = $clog2(CLKMON_WINDOW);
    // probe toggle flips every 2**PROBE_DIV_BITS monitored cycles
    localparam int PROBE_DIV_BITS = 4;
    // width of one window count
    localparam int CLKMON_COUNT_BITS = 16;

endpackage

`default_nettype wire

/* vlog.f */
turf_pkg.sv
device_dna_port.sv
clock_domain_probe.sv
id_statctrl_regs.sv
simple_clock_mon.sv
turf_id_ctrl.sv
tb_turf_id_ctrl.sv
